// File: include/sincos_table.svh
`ifndef SINCOS_TABLE_SVH
`define SINCOS_TABLE_SVH

// First quarter of a 256-point wave, 32767 * sin(2*pi*idx/256).
function automatic logic signed [rx_freq_shift_pkg::TRIG_WIDTH-1:0] quarter_sine(
  input logic [5:0] idx
);
  case (idx)
    6'd0:  return 16'sd0;
    6'd1:  return 16'sd804;
    6'd2:  return 16'sd1608;
    6'd3:  return 16'sd2410;
    6'd4:  return 16'sd3212;
    6'd5:  return 16'sd4011;
    6'd6:  return 16'sd4808;
    6'd7:  return 16'sd5602;
    6'd8:  return 16'sd6393;
    6'd9:  return 16'sd7179;
    6'd10: return 16'sd7962;
    6'd11: return 16'sd8739;
    6'd12: return 16'sd9512;
    6'd13: return 16'sd10278;
    6'd14: return 16'sd11039;
    6'd15: return 16'sd11793;
    6'd16: return 16'sd12539;
    6'd17: return 16'sd13279;
    6'd18: return 16'sd14010;
    6'd19: return 16'sd14732;
    6'd20: return 16'sd15446;
    6'd21: return 16'sd16151;
    6'd22: return 16'sd16846;
    6'd23: return 16'sd17530;
    6'd24: return 16'sd18204;
    6'd25: return 16'sd18868;
    6'd26: return 16'sd19519;
    6'd27: return 16'sd20159;
    6'd28: return 16'sd20787;
    6'd29: return 16'sd21403;
    6'd30: return 16'sd22005;
    6'd31: return 16'sd22594;
    6'd32: return 16'sd23170;
    6'd33: return 16'sd23731;
    6'd34: return 16'sd24279;
    6'd35: return 16'sd24811;
    6'd36: return 16'sd25329;
    6'd37: return 16'sd25832;
    6'd38: return 16'sd26319;
    6'd39: return 16'sd26790;
    6'd40: return 16'sd27245;
    6'd41: return 16'sd27683;
    6'd42: return 16'sd28105;
    6'd43: return 16'sd28510;
    6'd44: return 16'sd28898;
    6'd45: return 16'sd29268;
    6'd46: return 16'sd29621;
    6'd47: return 16'sd29956;
    6'd48: return 16'sd30273;
    6'd49: return 16'sd30571;
    6'd50: return 16'sd30852;
    6'd51: return 16'sd31113;
    6'd52: return 16'sd31356;
    6'd53: return 16'sd31580;
    6'd54: return 16'sd31785;
    6'd55: return 16'sd31971;
    6'd56: return 16'sd32137;
    6'd57: return 16'sd32285;
    6'd58: return 16'sd32412;
    6'd59: return 16'sd32521;
    6'd60: return 16'sd32609;
    6'd61: return 16'sd32678;
    6'd62: return 16'sd32728;
    default: return 16'sd32757;  // Index 63.
  endcase
endfunction

`endif

// File: design/rx_freq_shift_pkg.sv
`default_nettype none

package rx_freq_shift_pkg;

  localparam int DATA_WIDTH     = 16;  // Input and output I/Q width.
  localparam int PHASE_WIDTH    = 24;  // Phase accumulator width.
  localparam int LUT_ADDR_WIDTH = 8;   // Top phase bits that address the wave.
  localparam int TRIG_WIDTH     = 16;  // Signed sine and cosine width.
  localparam int SCALE_SHIFT    = 12;  // Fraction bits of the gain.
  localparam int MIX_WIDTH      = 33;  // Width of the mixer product sums.
  localparam int MIX_SHIFT      = 15;  // Right shift when rounding the mixer output.

  localparam logic signed [TRIG_WIDTH-1:0] TRIG_PEAK       = 16'sd32767;
  localparam logic [PHASE_WIDTH-1:0]       DPH_INC_DEFAULT = 24'd2048;
  localparam logic [PHASE_WIDTH-1:0]       START_PHASE     = 24'd0;
  localparam logic signed [MIX_WIDTH-1:0]  ROUND_BIAS      = 33'sd16384;  // Half an output LSB.

  typedef struct packed {
    logic signed [DATA_WIDTH-1:0] i;
    logic signed [DATA_WIDTH-1:0] q;
  } iq_sample_t;

  typedef struct packed {
    logic signed [TRIG_WIDTH-1:0] sin;
    logic signed [TRIG_WIDTH-1:0] cos;
  } sincos_t;

  typedef struct packed {
    logic signed [MIX_WIDTH-1:0] i;
    logic signed [MIX_WIDTH-1:0] q;
  } mix_iq_t;

  // Clamps a wide signed value to the signed DATA_WIDTH range.
  function automatic logic signed [DATA_WIDTH-1:0] saturate(
    input logic signed [MIX_WIDTH-1:0] x
  );
    logic [MIX_WIDTH-DATA_WIDTH:0] top;
    top = x[MIX_WIDTH-1:DATA_WIDTH-1];
    if (~|top || &top) begin
      return x[DATA_WIDTH-1:0];  // Upper bits are pure sign extension.
    end
    if (x[MIX_WIDTH-1]) begin
      return {1'b1, {(DATA_WIDTH-1){1'b0}}};
    end
    return {1'b0, {(DATA_WIDTH-1){1'b1}}};
  endfunction

endpackage

`default_nettype wire

// File: design/iq_scaler.sv
`timescale 1ns/1ps
`default_nettype none

module iq_scaler (
  input  wire                           clk,
  input  wire                           i_reset,
  input  wire                           i_advance,
  input  wire                           i_valid,
  input  wire rx_freq_shift_pkg::iq_sample_t i_sample,
  input  wire  [15:0]                   i_scale,
  output logic                          o_valid,
  output rx_freq_shift_pkg::iq_sample_t o_sample
);

  logic        [15:0]                           gain;
  logic signed [rx_freq_shift_pkg::MIX_WIDTH-1:0] prod_i;
  logic signed [rx_freq_shift_pkg::MIX_WIDTH-1:0] prod_q;
  logic signed [rx_freq_shift_pkg::MIX_WIDTH-1:0] shifted_i;
  logic signed [rx_freq_shift_pkg::MIX_WIDTH-1:0] shifted_q;

  assign gain = (i_scale == 16'd0) ? 16'd1 : i_scale;  // Zero gain is the smallest step.

  // The gain is unsigned, so it gets a zero sign bit before the signed multiply.
  assign prod_i = i_sample.i * $signed({1'b0, gain});
  assign prod_q = i_sample.q * $signed({1'b0, gain});

  assign shifted_i = prod_i >>> rx_freq_shift_pkg::SCALE_SHIFT;  // Drop the fraction bits.
  assign shifted_q = prod_q >>> rx_freq_shift_pkg::SCALE_SHIFT;

  always_ff @(posedge clk) begin
    if (i_reset) begin
      o_valid <= 1'b0;
    end else if (i_advance) begin
      o_valid <= i_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (i_advance) begin
      o_sample.i <= rx_freq_shift_pkg::saturate(shifted_i);
      o_sample.q <= rx_freq_shift_pkg::saturate(shifted_q);
    end
  end

endmodule

`default_nettype wire

// File: design/phase_nco.sv
`timescale 1ns/1ps
`default_nettype none

module phase_nco (
  input  wire                                       clk,
  input  wire                                       i_reset,
  input  wire                                       i_sync_clear,
  input  wire                                       i_accept,
  input  wire  [rx_freq_shift_pkg::PHASE_WIDTH-1:0] i_phase_inc,
  output logic [rx_freq_shift_pkg::PHASE_WIDTH-1:0] o_phase,
  output logic [rx_freq_shift_pkg::PHASE_WIDTH-1:0] o_sample_count
);

  logic [rx_freq_shift_pkg::PHASE_WIDTH-1:0] phase_inc;

  // A zero increment word selects the default tone.
  assign phase_inc = (i_phase_inc == '0) ? rx_freq_shift_pkg::DPH_INC_DEFAULT : i_phase_inc;

  // o_phase always holds the phase for the next sample to be accepted.
  always_ff @(posedge clk) begin
    if (i_reset || i_sync_clear) begin
      o_phase        <= rx_freq_shift_pkg::START_PHASE;
      o_sample_count <= '0;
    end else if (i_accept) begin
      o_phase        <= o_phase + phase_inc;  // Wraps modulo 2**PHASE_WIDTH.
      o_sample_count <= o_sample_count + 1'b1;
    end
  end

endmodule

`default_nettype wire

// File: design/sincos_lut.sv
`timescale 1ns/1ps
`default_nettype none

module sincos_lut (
  input  wire                                      clk,
  input  wire                                      i_reset,
  input  wire                                      i_advance,
  input  wire [rx_freq_shift_pkg::PHASE_WIDTH-1:0] i_phase,
  output rx_freq_shift_pkg::sincos_t               o_trig
);

  `include "sincos_table.svh"

  // Maps a full-wave address onto the quarter table by quadrant.
  function automatic logic signed [rx_freq_shift_pkg::TRIG_WIDTH-1:0] fold_wave(
    input logic [rx_freq_shift_pkg::LUT_ADDR_WIDTH-1:0] addr
  );
    logic [5:0]                                    idx;
    logic [5:0]                                    mirror;
    logic signed [rx_freq_shift_pkg::TRIG_WIDTH-1:0] mag;
    idx    = addr[5:0];
    mirror = 6'd0 - idx;  // 64 - idx for the descending quadrants.
    if (!addr[6]) begin
      mag = quarter_sine(idx);
    end else if (idx == 6'd0) begin
      mag = rx_freq_shift_pkg::TRIG_PEAK;  // The crest lies outside the quarter table.
    end else begin
      mag = quarter_sine(mirror);
    end
    return addr[7] ? -mag : mag;  // Second half of the wave is negative.
  endfunction

  logic [rx_freq_shift_pkg::LUT_ADDR_WIDTH-1:0] addr_sin;
  logic [rx_freq_shift_pkg::LUT_ADDR_WIDTH-1:0] addr_cos;

  assign addr_sin = i_phase[rx_freq_shift_pkg::PHASE_WIDTH-1 -: rx_freq_shift_pkg::LUT_ADDR_WIDTH];
  assign addr_cos = addr_sin + 8'd64;  // Cosine leads sine by a quarter turn.

  // Loads together with the scaler, so both reach the mixer in the same cycle.
  always_ff @(posedge clk) begin
    if (i_reset) begin
      o_trig <= '0;
    end else if (i_advance) begin
      o_trig.sin <= fold_wave(addr_sin);
      o_trig.cos <= fold_wave(addr_cos);
    end
  end

endmodule

`default_nettype wire

// File: design/complex_mixer.sv
`timescale 1ns/1ps
`default_nettype none

module complex_mixer (
  input  wire                           clk,
  input  wire                           i_reset,
  input  wire                           i_advance,
  input  wire                           i_valid,
  input  wire rx_freq_shift_pkg::iq_sample_t i_sample,
  input  wire rx_freq_shift_pkg::sincos_t    i_trig,
  output logic                          o_valid,
  output rx_freq_shift_pkg::mix_iq_t    o_mix
);

  localparam int PROD_WIDTH = rx_freq_shift_pkg::DATA_WIDTH + rx_freq_shift_pkg::TRIG_WIDTH;

  logic signed [PROD_WIDTH-1:0]                   prod_ic;
  logic signed [PROD_WIDTH-1:0]                   prod_qs;
  logic signed [PROD_WIDTH-1:0]                   prod_is;
  logic signed [PROD_WIDTH-1:0]                   prod_qc;
  logic signed [rx_freq_shift_pkg::MIX_WIDTH-1:0] sum_i;
  logic signed [rx_freq_shift_pkg::MIX_WIDTH-1:0] sum_q;

  assign prod_ic = i_sample.i * i_trig.cos;
  assign prod_qs = i_sample.q * i_trig.sin;
  assign prod_is = i_sample.i * i_trig.sin;
  assign prod_qc = i_sample.q * i_trig.cos;

  // One extra bit keeps the sum and difference exact.
  assign sum_i = prod_ic - prod_qs;
  assign sum_q = prod_is + prod_qc;

  always_ff @(posedge clk) begin
    if (i_reset) begin
      o_valid <= 1'b0;
    end else if (i_advance) begin
      o_valid <= i_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (i_advance) begin
      o_mix.i <= sum_i;
      o_mix.q <= sum_q;
    end
  end

endmodule

`default_nettype wire

// File: design/round_clip.sv
`timescale 1ns/1ps
`default_nettype none

module round_clip (
  input  wire                           clk,
  input  wire                           i_reset,
  input  wire                           i_valid,
  input  wire rx_freq_shift_pkg::mix_iq_t i_mix,
  input  wire                           i_out_ready,
  output logic                          o_advance,
  output logic                          o_out_valid,
  output rx_freq_shift_pkg::iq_sample_t o_sample
);

  logic signed [rx_freq_shift_pkg::MIX_WIDTH-1:0] biased_i;
  logic signed [rx_freq_shift_pkg::MIX_WIDTH-1:0] biased_q;
  logic signed [rx_freq_shift_pkg::MIX_WIDTH-1:0] scaled_i;
  logic signed [rx_freq_shift_pkg::MIX_WIDTH-1:0] scaled_q;

  // The whole pipeline moves when this register is empty or being drained.
  assign o_advance = ~o_out_valid | i_out_ready;

  assign biased_i = i_mix.i + rx_freq_shift_pkg::ROUND_BIAS;  // Round half up.
  assign biased_q = i_mix.q + rx_freq_shift_pkg::ROUND_BIAS;
  assign scaled_i = biased_i >>> rx_freq_shift_pkg::MIX_SHIFT;
  assign scaled_q = biased_q >>> rx_freq_shift_pkg::MIX_SHIFT;

  always_ff @(posedge clk) begin
    if (i_reset) begin
      o_out_valid <= 1'b0;
    end else if (o_advance) begin
      o_out_valid <= i_valid;
    end
  end

  // Holds its value while the consumer stalls.
  always_ff @(posedge clk) begin
    if (o_advance) begin
      o_sample.i <= rx_freq_shift_pkg::saturate(scaled_i);
      o_sample.q <= rx_freq_shift_pkg::saturate(scaled_q);
    end
  end

endmodule

`default_nettype wire

// File: design/rx_freq_shift.sv
`timescale 1ns/1ps
`default_nettype none

module rx_freq_shift (
  input  wire                                       clk,
  input  wire                                       i_reset,
  input  wire                                       i_sync_clear,
  input  wire                                       i_in_valid,
  output logic                                      o_in_ready,
  input  wire rx_freq_shift_pkg::iq_sample_t        i_in_sample,
  input  wire  [15:0]                               i_scale,
  input  wire  [rx_freq_shift_pkg::PHASE_WIDTH-1:0] i_phase_inc,
  output logic                                      o_out_valid,
  input  wire                                       i_out_ready,
  output rx_freq_shift_pkg::iq_sample_t             o_out_sample,
  output logic [rx_freq_shift_pkg::PHASE_WIDTH-1:0] o_phase,
  output logic [rx_freq_shift_pkg::PHASE_WIDTH-1:0] o_sample_count
);

  logic                          advance;
  logic                          accept;
  logic                          scaled_valid;
  logic                          mix_valid;
  rx_freq_shift_pkg::iq_sample_t scaled_sample;
  rx_freq_shift_pkg::sincos_t    trig;
  rx_freq_shift_pkg::mix_iq_t    mix;

  assign o_in_ready = advance;
  assign accept     = i_in_valid & advance;  // A sample enters on this edge.

  iq_scaler u_iq_scaler (
    .clk       (clk),
    .i_reset   (i_reset),
    .i_advance (advance),
    .i_valid   (i_in_valid),
    .i_sample  (i_in_sample),
    .i_scale   (i_scale),
    .o_valid   (scaled_valid),
    .o_sample  (scaled_sample)
  );

  phase_nco u_phase_nco (
    .clk            (clk),
    .i_reset        (i_reset),
    .i_sync_clear   (i_sync_clear),
    .i_accept       (accept),
    .i_phase_inc    (i_phase_inc),
    .o_phase        (o_phase),
    .o_sample_count (o_sample_count)
  );

  sincos_lut u_sincos_lut (
    .clk       (clk),
    .i_reset   (i_reset),
    .i_advance (advance),
    .i_phase   (o_phase),  // Phase of the sample being accepted.
    .o_trig    (trig)
  );

  complex_mixer u_complex_mixer (
    .clk       (clk),
    .i_reset   (i_reset),
    .i_advance (advance),
    .i_valid   (scaled_valid),
    .i_sample  (scaled_sample),
    .i_trig    (trig),
    .o_valid   (mix_valid),
    .o_mix     (mix)
  );

  round_clip u_round_clip (
    .clk         (clk),
    .i_reset     (i_reset),
    .i_valid     (mix_valid),
    .i_mix       (mix),
    .i_out_ready (i_out_ready),
    .o_advance   (advance),
    .o_out_valid (o_out_valid),
    .o_sample    (o_out_sample)
  );

endmodule

`default_nettype wire

// File: sim/tb_rx_freq_shift.sv
`timescale 1ns/1ps
`default_nettype none

module tb_rx_freq_shift;

  localparam int CLK_PERIOD = 40;
  localparam int TBL_LEN    = 18;

  typedef struct packed {
    logic signed [15:0] i;
    logic signed [15:0] q;
    logic [15:0]        gain;
    logic [23:0]        inc;
    logic               clear;
    logic               bp;
  } stim_t;

  logic clk = 1'b0;
  logic i_reset, i_sync_clear, i_in_valid, i_out_ready, o_in_ready, o_out_valid;
  logic [15:0] i_scale;
  logic [rx_freq_shift_pkg::PHASE_WIDTH-1:0] i_phase_inc, o_phase, o_sample_count;
  rx_freq_shift_pkg::iq_sample_t i_in_sample, o_out_sample;

  stim_t table_q [TBL_LEN];
  rx_freq_shift_pkg::iq_sample_t exp_q [$];
  rx_freq_shift_pkg::iq_sample_t held_sample;
  logic [rx_freq_shift_pkg::PHASE_WIDTH-1:0] model_phase = rx_freq_shift_pkg::START_PHASE;
  logic [rx_freq_shift_pkg::PHASE_WIDTH-1:0] model_count = '0;
  logic bp_mode = 1'b0;
  logic held = 1'b0, started = 1'b0, acc_seen = 1'b0, first_seen = 1'b0;
  int   cycle = 0, first_acc = 0;

  // The LUT already expanded the header, so its guard is cleared for this scope.
  `undef SINCOS_TABLE_SVH
  `include "sincos_table.svh"

  rx_freq_shift UUT (
    .clk(clk), .i_reset(i_reset), .i_sync_clear(i_sync_clear),
    .i_in_valid(i_in_valid), .o_in_ready(o_in_ready), .i_in_sample(i_in_sample),
    .i_scale(i_scale), .i_phase_inc(i_phase_inc), .o_out_valid(o_out_valid),
    .i_out_ready(i_out_ready), .o_out_sample(o_out_sample), .o_phase(o_phase),
    .o_sample_count(o_sample_count)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  task automatic report_failure(input string msg);
    $display("%s", msg);
    $display("SOME TESTS FAILED");
    $fatal(1);
  endtask

  task automatic compare_sample(input string name, input rx_freq_shift_pkg::iq_sample_t got,
                                input rx_freq_shift_pkg::iq_sample_t exp);
    if (got !== exp) begin
      report_failure($sformatf("** Error: %s got %h expected %h", name, got, exp));
    end
  endtask

  task automatic compare_count(input string name,
                               input logic [rx_freq_shift_pkg::PHASE_WIDTH-1:0] got,
                               input logic [rx_freq_shift_pkg::PHASE_WIDTH-1:0] exp);
    if (got !== exp) begin
      report_failure($sformatf("** Error: %s got %h expected %h", name, got, exp));
    end
  endtask

  task automatic compare_flag(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      report_failure($sformatf("** Error: %s got %h expected %h", name, got, exp));
    end
  endtask

  function automatic logic signed [15:0] clamp16(input longint v);
    return (v > 32767) ? 16'sh7FFF : ((v < -32768) ? 16'sh8000 : 16'(v));
  endfunction

  // One point of the 256-point wave, built from the quarter table by symmetry.
  function automatic longint wave_point(input int addr);
    int     half;
    longint mag;
    half = addr % 128;
    mag  = (half == 64) ? 32767 : quarter_sine(6'((half > 64) ? 128 - half : half));
    return (addr >= 128) ? -mag : mag;
  endfunction

  function automatic rx_freq_shift_pkg::iq_sample_t expected_out(
    input rx_freq_shift_pkg::iq_sample_t x, input logic [15:0] gain,
    input logic [rx_freq_shift_pkg::PHASE_WIDTH-1:0] phase
  );
    longint g, si, sq, s, c;
    int     addr;
    rx_freq_shift_pkg::iq_sample_t r;
    g    = (gain == 16'd0) ? 1 : longint'(gain);  // Zero gain counts as one step.
    si   = clamp16((longint'(x.i) * g) >>> 12);
    sq   = clamp16((longint'(x.q) * g) >>> 12);
    addr = int'(phase[23:16]);
    s    = wave_point(addr);
    c    = wave_point((addr + 64) % 256);
    r.i  = clamp16((si * c - sq * s + 16384) >>> 15);
    r.q  = clamp16((si * s + sq * c + 16384) >>> 15);
    return r;
  endfunction

  // Sees the inputs that the next rising edge will act on, and the outputs in between.
  always @(negedge clk) begin
    if (!i_reset) begin
      if (!started) begin
        compare_flag("o_out_valid", o_out_valid, 1'b0);
        compare_flag("o_in_ready", o_in_ready, 1'b1);
        started = 1'b1;
      end
      compare_count("o_phase", o_phase, model_phase);
      compare_count("o_sample_count", o_sample_count, model_count);
      if (held) begin
        compare_flag("o_out_valid", o_out_valid, 1'b1);  // A stalled result must stay put.
        compare_sample("o_out_sample", o_out_sample, held_sample);
      end
      if (o_out_valid && !first_seen) begin
        first_seen = 1'b1;
        if (!acc_seen || cycle - first_acc != 3) begin
          report_failure("The first sample did not come out three edges after acceptance.");
        end
      end
      if (o_out_valid && !i_out_ready) begin
        compare_flag("o_in_ready", o_in_ready, 1'b0);
      end
      held        = o_out_valid && !i_out_ready;
      held_sample = o_out_sample;
      if (o_out_valid && i_out_ready) begin
        if (exp_q.size() == 0) begin
          report_failure("An output was consumed while no sample was expected.");
        end
        compare_sample("o_out_sample", o_out_sample, exp_q.pop_front());
      end
      if (i_in_valid && o_in_ready) begin
        exp_q.push_back(expected_out(i_in_sample, i_scale, model_phase));
        if (!acc_seen) begin
          acc_seen  = 1'b1;
          first_acc = cycle;
        end
      end
      if (i_sync_clear) begin
        model_phase = rx_freq_shift_pkg::START_PHASE;  // Clear wins over an acceptance.
        model_count = '0;
      end else if (i_in_valid && o_in_ready) begin
        model_phase = model_phase + ((i_phase_inc == '0) ?
                      rx_freq_shift_pkg::DPH_INC_DEFAULT : i_phase_inc);
        model_count = model_count + 1;
      end
      cycle++;
    end
  end

  always @(posedge clk) begin
    #2 i_out_ready = bp_mode ? (($urandom % 3) != 0) : 1'b1;
  end

  task automatic apply_entry(input stim_t e);
    logic taken;
    if (($urandom % 4) == 0) begin
      i_in_valid   = 1'b0;  // Idle gap between samples.
      i_sync_clear = 1'b0;
      @(posedge clk);
      #2;
    end
    bp_mode      = e.bp;
    i_in_valid   = 1'b1;
    i_in_sample  = '{i: e.i, q: e.q};
    i_scale      = e.gain;
    i_phase_inc  = e.inc;
    i_sync_clear = e.clear;
    taken        = 1'b0;
    while (!taken) begin
      @(negedge clk);
      taken = o_in_ready;
      @(posedge clk);
      #2;
    end
    i_in_valid   = 1'b0;
    i_sync_clear = 1'b0;
  endtask

  initial begin
    #(TBL_LEN * 64 * CLK_PERIOD);
    report_failure("Timeout: the outputs stalled before every sample came out.");
  end

  initial begin
    void'($urandom(81));
    i_reset      = 1'b1;
    i_sync_clear = 1'b0;
    i_in_valid   = 1'b0;
    i_out_ready  = 1'b1;
    i_in_sample  = '0;
    i_scale      = 16'h1000;
    i_phase_inc  = '0;
    table_q[0]  = '{16'sd1000, -16'sd2000, 16'h1000, 24'h000000, 1'b0, 1'b0};
    table_q[1]  = '{-16'sd1500, 16'sd700, 16'h1000, 24'h000000, 1'b0, 1'b0};
    table_q[2]  = '{16'sd12000, 16'sd8000, 16'h0000, 24'h000000, 1'b0, 1'b0};
    table_q[3]  = '{-16'sd300, 16'sd32000, 16'h0800, 24'h000000, 1'b0, 1'b0};
    table_q[4]  = '{16'sd20000, -16'sd20000, 16'h1000, 24'h200000, 1'b0, 1'b0};
    table_q[5]  = '{16'sd32767, -16'sd32768, 16'h7FFF, 24'h200000, 1'b0, 1'b0};
    table_q[6]  = '{-16'sd32768, -16'sd32768, 16'h7FFF, 24'h200000, 1'b0, 1'b0};
    table_q[7]  = '{16'sd32767, 16'sd32767, 16'h7FFF, 24'h200000, 1'b0, 1'b0};
    table_q[8]  = '{16'sd5000, 16'sd5000, 16'h2000, 24'h0F0F0F, 1'b0, 1'b1};
    table_q[9]  = '{-16'sd7000, 16'sd3000, 16'h1800, 24'h0F0F0F, 1'b0, 1'b1};
    table_q[10] = '{16'sd16000, -16'sd4000, 16'h1000, 24'h123456, 1'b0, 1'b1};
    table_q[11] = '{16'sd100, 16'sd200, 16'hFFFF, 24'h123456, 1'b0, 1'b1};
    table_q[12] = '{16'sd9000, -16'sd9000, 16'h1000, 24'h000000, 1'b1, 1'b0};
    table_q[13] = '{16'sd9000, -16'sd9000, 16'h1000, 24'h000000, 1'b0, 1'b1};
    table_q[14] = '{-16'sd12345, 16'sd2345, 16'h1000, 24'h400000, 1'b0, 1'b1};
    table_q[15] = '{16'sd30000, -16'sd30000, 16'h4000, 24'h400000, 1'b1, 1'b1};
    table_q[16] = '{16'sd4000, 16'sd4000, 16'h1000, 24'h800000, 1'b0, 1'b1};
    table_q[17] = '{-16'sd4000, 16'sd8000, 16'h1000, 24'h7FFFFF, 1'b0, 1'b0};
    repeat (16) @(posedge clk);
    #2 i_reset = 1'b0;
    for (int n = 0; n < TBL_LEN; n++) begin
      apply_entry(table_q[n]);
    end
    bp_mode = 1'b0;
    while (exp_q.size() != 0) begin
      @(negedge clk);
    end
    repeat (4) @(negedge clk);  // Any stray output after the last one is caught here.
    $display("ALL TESTS PASSED");
    $finish;
  end

endmodule

`default_nettype wire

// File: rx_freq_shift.f
+incdir+include
design/rx_freq_shift_pkg.sv
design/iq_scaler.sv
design/phase_nco.sv
design/sincos_lut.sv
design/complex_mixer.sv
design/round_clip.sv
design/rx_freq_shift.sv
sim/tb_rx_freq_shift.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Builds the testbench with Verilator, runs it and looks for the pass line in the log.
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing -Wno-fatal --top-module tb_rx_freq_shift \
  -f rx_freq_shift.f -o tb_sim > build.log 2>&1 \
  || { cat build.log; echo "Build failed"; exit 1; }
./obj_dir/tb_sim > sim.log 2>&1 || true
cat sim.log
grep -q "ALL TESTS PASSED" sim.log && echo "Simulation passed" \
  || { echo "Simulation failed"; exit 1; }
